// ==== src/routerPkg.sv ====
package routerPkg;

  // ##################################################
  // router ports
  // ##################################################

  localparam int numPorts = 5;
  localparam int portIdxWidth = 3;

  localparam logic [portIdxWidth-1:0] portLocal = 3'd0;
  localparam logic [portIdxWidth-1:0] portNorth = 3'd1;
  localparam logic [portIdxWidth-1:0] portEast = 3'd2;
  localparam logic [portIdxWidth-1:0] portWest = 3'd3;
  localparam logic [portIdxWidth-1:0] portSouth = 3'd4;

  // ##################################################
  // flit format
  // ##################################################

  localparam int flitTypeWidth = 3;

  localparam logic [flitTypeWidth-1:0] flitHead = 3'd1;
  localparam logic [flitTypeWidth-1:0] flitBody = 3'd2;
  localparam logic [flitTypeWidth-1:0] flitTail = 3'd3;

  // a head flit carries the packet length here, the other flits carry data
  localparam int payloadWidth = 12;

  // ##################################################
  // buffering and timing
  // ##################################################

  localparam int fifoDepth = 4;

  // must be at least payloadWidth so a count can reach any budget
  localparam int countWidth = 12;

endpackage

// ==== src/flitFifo.sv ====
`timescale 1ns/1ps

module flitFifo import routerPkg::*;
#(
  parameter int depth = fifoDepth
)
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  logic                     pop,
  input  logic [flitTypeWidth-1:0] inType,
  input  logic [payloadWidth-1:0]  inPayload,
  output logic [flitTypeWidth-1:0] headType,
  output logic [payloadWidth-1:0]  headPayload,
  output logic                     notEmpty,
  output logic                     notFull
);

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int occWidth = $clog2(depth + 1);

  logic [flitTypeWidth-1:0] typeMem [depth];
  logic [payloadWidth-1:0] payloadMem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [occWidth-1:0] occupancy;
  logic doPush;
  logic doPop;

  assign notEmpty = (occupancy != '0);
  assign notFull = (occupancy != occWidth'(depth));

  // a push to a full buffer or a pop from an empty one is ignored
  assign doPush = push && notFull;
  assign doPop = pop && notEmpty;

  assign headType = typeMem[rdPtr];
  assign headPayload = payloadMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      typeMem[wrPtr] <= inType;
      payloadMem[wrPtr] <= inPayload;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      occupancy <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop)
        occupancy <= occupancy + 1'b1;
      else if (doPop && !doPush)
        occupancy <= occupancy - 1'b1;
    end
  end

endmodule

// ==== src/grantTimer.sv ====
`timescale 1ns/1ps

module grantTimer import routerPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    popHead,
  input  logic [payloadWidth-1:0] headLength,
  input  logic                    running,
  output logic                    timesUp
);

  logic [countWidth-1:0] budget;
  logic [countWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      // the packet length of the latest head flit becomes the holding budget
      // and the count of granted pops restarts from that head
      if (popHead)
      begin
        budget <= countWidth'(headLength);
        count <= '0;
      end
      else if (running)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == budget);

endmodule

// ==== src/outputArbiter.sv ====
`timescale 1ns/1ps

module outputArbiter import routerPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [numPorts-1:0]                    request,
  input  logic [numPorts-1:0]                    popHead,
  input  logic [numPorts-1:0][payloadWidth-1:0]  headLength,
  output logic [numPorts-1:0]                    grant,
  output logic                                   grantValid
);

  // bit 0 is idle, bit p+1 means input p holds the output
  localparam logic [numPorts:0] idleState = (numPorts + 1)'(1);

  logic [numPorts:0] stateReg;
  logic [numPorts:0] nextState;
  logic stateLegal;
  logic [numPorts-1:0] running;
  logic [numPorts-1:0] timesUp;
  logic [portIdxWidth-1:0] holder;
  logic holdNow;

  // ##################################################
  // budget timers
  // ##################################################

  assign running = grant & request;

  for (genvar p = 0; p < numPorts; p++)
  begin : gTimer
    grantTimer grantTimer_i (
      .clk        (clk),
      .rst        (rst),
      .popHead    (popHead[p]),
      .headLength (headLength[p]),
      .running    (running[p]),
      .timesUp    (timesUp[p])
    );
  end

  // ##################################################
  // grant state machine
  // ##################################################

  assign stateLegal = $onehot(stateReg);
  assign grant = stateLegal ? stateReg[numPorts:1] : '0;
  assign grantValid = |grant;

  // the holder keeps the link while it requests and its budget lasts
  assign holdNow = |(grant & request & ~timesUp);

  // from idle the search starts at the local port
  always_comb
  begin
    holder = portSouth;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p])
        holder = portIdxWidth'(p);
    end
  end

  always_comb
  begin
    int idx;
    logic found;
    nextState = idleState;
    found = 1'b0;
    idx = 0;
    if (!stateLegal)
      nextState = idleState;
    else if (holdNow)
      nextState = stateReg;
    else
    begin
      // an expired holder is skipped, so it falls to idle when it is alone
      for (int i = 1; i <= numPorts; i++)
      begin
        idx = (int'(holder) + i) % numPorts;
        if (!found && request[idx] && (i < numPorts || !grantValid))
        begin
          found = 1'b1;
          nextState = idleState << (idx + 1);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      stateReg <= idleState;
    else
      stateReg <= nextState;
  end

endmodule

// ==== src/switchTraversal.sv ====
`timescale 1ns/1ps

module switchTraversal import routerPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [numPorts-1:0]                    grant,
  input  logic                                   grantValid,
  input  logic [numPorts-1:0][flitTypeWidth-1:0] headType,
  input  logic [numPorts-1:0][payloadWidth-1:0]  headPayload,
  input  logic [numPorts-1:0]                    notEmpty,
  output logic [numPorts-1:0]                    pop,
  output logic [numPorts-1:0]                    popHead,
  output logic [numPorts-1:0][payloadWidth-1:0]  headLength,
  output logic                                   outValid,
  output logic [flitTypeWidth-1:0]               outType,
  output logic [payloadWidth-1:0]                outPayload,
  output logic [portIdxWidth-1:0]                outSource
);

  logic [flitTypeWidth-1:0] selType;
  logic [payloadWidth-1:0] selPayload;
  logic [portIdxWidth-1:0] selSource;

  assign pop = grantValid ? (grant & notEmpty) : '0;

  always_comb
  begin
    selType = '0;
    selPayload = '0;
    selSource = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      popHead[p] = pop[p] && (headType[p] == flitHead);
      headLength[p] = headPayload[p];
      if (grant[p])
      begin
        selType = headType[p];
        selPayload = headPayload[p];
        selSource = portIdxWidth'(p);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outType <= selType;
      outPayload <= selPayload;
      outSource <= selSource;
    end
  end

endmodule

// ==== src/routerOutputPort.sv ====
`timescale 1ns/1ps

module routerOutputPort import routerPkg::*;
#(
  parameter int depth = fifoDepth
)
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [numPorts-1:0]                    inValid,
  output logic [numPorts-1:0]                    inReady,
  input  logic [numPorts-1:0][flitTypeWidth-1:0] inType,
  input  logic [numPorts-1:0][payloadWidth-1:0]  inPayload,
  output logic                                   outValid,
  output logic [flitTypeWidth-1:0]               outType,
  output logic [payloadWidth-1:0]                outPayload,
  output logic [portIdxWidth-1:0]                outSource
);

  logic [numPorts-1:0] notEmpty;
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0] popHead;
  logic [numPorts-1:0] grant;
  logic grantValid;
  logic [numPorts-1:0][flitTypeWidth-1:0] headType;
  logic [numPorts-1:0][payloadWidth-1:0] headPayload;
  logic [numPorts-1:0][payloadWidth-1:0] headLength;

  // the buffer drops the push itself when full, so inValid goes straight in
  for (genvar p = 0; p < numPorts; p++)
  begin : gInput
    flitFifo #(.depth(depth)) flitFifo_i (
      .clk         (clk),
      .rst         (rst),
      .push        (inValid[p]),
      .pop         (pop[p]),
      .inType      (inType[p]),
      .inPayload   (inPayload[p]),
      .headType    (headType[p]),
      .headPayload (headPayload[p]),
      .notEmpty    (notEmpty[p]),
      .notFull     (inReady[p])
    );
  end

  outputArbiter outputArbiter_i (
    .clk        (clk),
    .rst        (rst),
    .request    (notEmpty),
    .popHead    (popHead),
    .headLength (headLength),
    .grant      (grant),
    .grantValid (grantValid)
  );

  switchTraversal switchTraversal_i (
    .clk         (clk),
    .rst         (rst),
    .grant       (grant),
    .grantValid  (grantValid),
    .headType    (headType),
    .headPayload (headPayload),
    .notEmpty    (notEmpty),
    .pop         (pop),
    .popHead     (popHead),
    .headLength  (headLength),
    .outValid    (outValid),
    .outType     (outType),
    .outPayload  (outPayload),
    .outSource   (outSource)
  );

endmodule

// ==== tb/routerOutputPort_properties.sv ====
`timescale 1ns/1ps

module routerOutputPortProperties import routerPkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic [numPorts-1:0] grant,
  input logic                grantValid,
  input logic [numPorts-1:0] pop,
  input logic [numPorts-1:0] notEmpty,
  input logic                outValid
);

  int failures = 0;

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    failures++;
    $error("grant has more than one bit set");
  end

  // the output register is loaded only from a granted cycle
  outAfterGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> $past(grantValid))
  else
  begin
    failures++;
    $error("outValid without grantValid in the previous cycle");
  end

  noEmptyPop: assert property (@(posedge clk) disable iff (rst) (pop & ~notEmpty) == '0)
  else
  begin
    failures++;
    $error("pop issued to an empty buffer");
  end

endmodule

// ==== tb/routerOutputPortTb.sv ====
`timescale 1ns/1ps

module routerOutputPortTb import routerPkg::*;
();

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  logic [numPorts-1:0][flitTypeWidth-1:0] inType;
  logic [numPorts-1:0][payloadWidth-1:0] inPayload;
  logic outValid;
  logic [flitTypeWidth-1:0] outType;
  logic [payloadWidth-1:0] outPayload;
  logic [portIdxWidth-1:0] outSource;

  // the stimulus of each input doubles as its model queue
  logic [flitTypeWidth-1:0] stimType [numPorts][128];
  logic [payloadWidth-1:0] stimPayload [numPorts][128];
  int stimCount [numPorts];
  int sendIdx [numPorts];
  int pushedCount [numPorts];
  int poppedCount [numPorts];
  logic [numPorts-1:0] pushSeen;
  logic [numPorts-1:0] sawFull;

  // arbiter model, holder is -1 while idle
  int holder;
  logic [countWidth-1:0] runCount [numPorts];
  logic [countWidth-1:0] budget [numPorts];

  logic expValid;
  logic [flitTypeWidth-1:0] expType;
  logic [payloadWidth-1:0] expPayload;
  int expSource;
  int totalFlits;
  int receivedCount;
  int cycleCount;
  int cycleLimit;
  int errorCount;

  routerOutputPort routerOutputPort_i (
    .clk        (clk),
    .rst        (rst),
    .inValid    (inValid),
    .inReady    (inReady),
    .inType     (inType),
    .inPayload  (inPayload),
    .outValid   (outValid),
    .outType    (outType),
    .outPayload (outPayload),
    .outSource  (outSource)
  );

  bind routerOutputPort routerOutputPortProperties routerOutputPortProperties_i (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .grantValid (grantValid),
    .pop        (pop),
    .notEmpty   (notEmpty),
    .outValid   (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ##################################################
  // stimulus
  // ##################################################

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic appendFlit(input int p, input logic [flitTypeWidth-1:0] kind,
                            input logic [payloadWidth-1:0] data);
    stimType[p][stimCount[p]] = kind;
    stimPayload[p][stimCount[p]] = data;
    stimCount[p]++;
  endtask

  // whole packets, a head with a length of 0 to 6 and that many body flits before the tail
  task automatic buildPackets();
    int length;
    totalFlits = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      stimCount[p] = 0;
      while (stimCount[p] < 80)
      begin
        length = $urandom_range(6, 0);
        appendFlit(p, flitHead, payloadWidth'(length));
        for (int b = 0; b < length; b++)
          appendFlit(p, flitBody, payloadWidth'($urandom));
        appendFlit(p, flitTail, payloadWidth'($urandom));
      end
      totalFlits += stimCount[p];
    end
  endtask

  // sparse traffic first, then a flood that fills the buffers
  task automatic driveInputs();
    int validPct;
    validPct = (cycleCount < 100) ? 15 : 95;
    for (int p = 0; p < numPorts; p++)
    begin
      if (pushSeen[p])
      begin
        sendIdx[p]++;
        inValid[p] = 1'b0;
      end
      if (!inValid[p] && sendIdx[p] < stimCount[p] && $urandom_range(99, 0) < validPct)
      begin
        inValid[p] = 1'b1;
        inType[p] = stimType[p][sendIdx[p]];
        inPayload[p] = stimPayload[p][sendIdx[p]];
      end
    end
  endtask

  // ##################################################
  // reference model
  // ##################################################

  task automatic predictCycle();
    logic [numPorts-1:0] req;
    logic timesUp;
    int start;
    int next;
    int idx;
    cycleCount++;
    compareValue("outValid", 32'(outValid), 32'(expValid));
    if (expValid)
    begin
      compareValue("outSource", 32'(outSource), expSource);
      compareValue("outType", 32'(outType), 32'(expType));
      compareValue("outPayload", 32'(outPayload), 32'(expPayload));
      receivedCount++;
    end
    for (int p = 0; p < numPorts; p++)
    begin
      req[p] = (pushedCount[p] != poppedCount[p]);
      pushSeen[p] = inValid[p] && (pushedCount[p] - poppedCount[p] < fifoDepth);
      compareValue($sformatf("inReady[%0d]", p), 32'(inReady[p]),
                   32'(pushedCount[p] - poppedCount[p] < fifoDepth));
      if (!inReady[p])
        sawFull[p] = 1'b1;
    end
    expValid = 1'b0;
    timesUp = 1'b0;
    if (holder >= 0)
    begin
      timesUp = (runCount[holder] == budget[holder]);
      if (req[holder])
      begin
        expValid = 1'b1;
        expSource = holder;
        expType = stimType[holder][poppedCount[holder]];
        expPayload = stimPayload[holder][poppedCount[holder]];
        poppedCount[holder]++;
        if (expType == flitHead)
          budget[holder] = countWidth'(expPayload);
      end
    end
    for (int p = 0; p < numPorts; p++)
      runCount[p] = (p == holder && req[p]) ? runCount[p] + 1'b1 : '0;
    // pops are counted from the latest head pop of the holder
    if (expValid && expType == flitHead)
      runCount[holder] = '0;
    // a holder that stops requesting or runs out of budget passes the grant on
    if (!(holder >= 0 && req[holder] && !timesUp))
    begin
      start = (holder >= 0) ? holder : numPorts - 1;
      next = -1;
      for (int i = 1; i <= numPorts; i++)
      begin
        idx = (start + i) % numPorts;
        if (next < 0 && req[idx] && (i < numPorts || holder < 0))
          next = idx;
      end
      holder = next;
    end
    for (int p = 0; p < numPorts; p++)
      if (pushSeen[p])
        pushedCount[p]++;
  endtask

  always @(negedge clk)
  begin
    if (!rst)
      predictCycle();
  end

  // ##################################################
  // run control
  // ##################################################

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    inType = '0;
    inPayload = '0;
    pushSeen = '0;
    sawFull = '0;
    holder = -1;
    expValid = 1'b0;
    expType = '0;
    expPayload = '0;
    expSource = 0;
    receivedCount = 0;
    cycleCount = 0;
    errorCount = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      sendIdx[p] = 0;
      pushedCount[p] = 0;
      poppedCount[p] = 0;
      runCount[p] = '0;
      budget[p] = '0;
    end
    void'($urandom(32'h92c81a05));
    buildPackets();
    cycleLimit = 20 * totalFlits;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    while (receivedCount < totalFlits)
    begin
      @(posedge clk);
      #1;
      driveInputs();
    end
    repeat (5) @(posedge clk);
    if (!sawFull[portLocal])
    begin
      errorCount++;
      $display("the local input buffer never filled up, so back-pressure went untested");
    end
    errorCount += routerOutputPort_i.routerOutputPortProperties_i.failures;
    $display("done: %0d of %0d flits checked, %0d errors", receivedCount, totalFlits, errorCount);
    if (errorCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    @(negedge rst);
    while (cycleCount < cycleLimit)
      @(negedge clk);
    errorCount++;
    $display("timeout: only %0d of %0d flits left the router within %0d cycles",
             receivedCount, totalFlits, cycleLimit);
    $display("done: %0d of %0d flits checked, %0d errors", receivedCount, totalFlits, errorCount);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== routerOutputPort.f ====
src/routerPkg.sv
src/flitFifo.sv
src/grantTimer.sv
src/outputArbiter.sv
src/switchTraversal.sv
src/routerOutputPort.sv
tb/routerOutputPort_properties.sv
tb/routerOutputPortTb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS := --timing --assert
TOP := routerOutputPortTb
FILELIST := routerOutputPort.f
OBJ_DIR := obj_dir
RUN_ARGS := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
